// ==== source/rv_mini_pkg.sv ====
////////////////////////////////////////
// Shared widths, opcodes and instruction
// views for the mini RISC-V core
////////////////////////////////////////

package rv_mini_pkg;

  // Data and address width
  localparam int XLEN = 32;
  // Register index width, 32 entries
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0] word_t;

  // One instruction word, three decodings of the same bits
  typedef union packed {
    struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } r_fmt;
    struct packed {
      logic [11:0]       imm;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } i_fmt;
    struct packed {
      logic [6:0]        imm_hi;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [4:0]        imm_lo;
      logic [6:0]        opcode;
    } s_fmt;
  } instr_t;

  // Standard RV32I major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // ADDI x0,x0,0
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== source/rv_mini_fetch.sv ====
////////////////////////////////////////
// Sequential prefetch, one-entry buffer
////////////////////////////////////////

module rv_mini_fetch #(
  parameter rv_mini_pkg::word_t BOOT_ADDR = '0
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Instruction side of the shared bus
  output logic                if_req_o,
  output rv_mini_pkg::word_t  if_addr_o,
  input  logic                if_gnt_i,
  input  logic                if_rvalid_i,
  input  rv_mini_pkg::word_t  if_rdata_i,
  // Buffered instruction towards execute
  output logic                instr_valid_o,
  output rv_mini_pkg::instr_t instr_o,
  input  logic                instr_take_i
);

  rv_mini_pkg::word_t  fetch_addr_q;
  logic                outstanding_q;
  logic                buf_valid_q;
  rv_mini_pkg::instr_t buf_instr_q;
  // Low through reset and the first cycle after it
  logic                started_q;

  // Slot empty or emptied by execute this cycle, and bus side idle
  assign if_req_o      = started_q && (!buf_valid_q || instr_take_i) && !outstanding_q;
  assign if_addr_o     = fetch_addr_q;
  assign instr_valid_o = buf_valid_q;
  assign instr_o       = buf_instr_q;

  // One quiet bus cycle after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      started_q <= 1'b0;
    end else begin
      started_q <= 1'b1;
    end
  end

  // Address only steps on handshake, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_addr_q  <= BOOT_ADDR;
      outstanding_q <= 1'b0;
    end else if (if_req_o && if_gnt_i) begin
      fetch_addr_q  <= fetch_addr_q + rv_mini_pkg::word_t'(4);
      outstanding_q <= 1'b1;
    end else if (if_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  // Response always lands in an empty slot
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buf_valid_q <= 1'b0;
    end else if (if_rvalid_i) begin
      buf_valid_q <= 1'b1;
    end else if (instr_take_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (if_rvalid_i) begin
      buf_instr_q <= if_rdata_i;
    end
  end

  // Responses only answer our own outstanding request, into an empty slot
  a_rvalid_when_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
    if_rvalid_i |-> (outstanding_q && !buf_valid_q));

endmodule

// ==== source/rv_mini_lsu.sv ====
////////////////////////////////////////
// Load/store sequencer, one bus access
////////////////////////////////////////

module rv_mini_lsu (
  input  logic               clk_i,
  input  logic               reset_i,
  // Request from execute
  input  logic               ls_start_i,
  input  logic               ls_we_i,
  input  rv_mini_pkg::word_t ls_addr_i,
  input  rv_mini_pkg::word_t ls_wdata_i,
  output logic               ls_done_o,
  output rv_mini_pkg::word_t ls_rdata_o,
  // Data side of the shared bus
  output logic               lsu_req_o,
  output logic               lsu_we_o,
  output rv_mini_pkg::word_t lsu_addr_o,
  output rv_mini_pkg::word_t lsu_wdata_o,
  input  logic               lsu_gnt_i,
  input  logic               lsu_rvalid_i,
  input  rv_mini_pkg::word_t lsu_rdata_i
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REQ  = 2'd1;
  localparam logic [1:0] ST_WAIT = 2'd2;

  logic [1:0] state_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (ls_start_i) state_q <= ST_REQ;
        ST_REQ:  if (lsu_gnt_i) state_q <= ST_WAIT;
        ST_WAIT: if (lsu_rvalid_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Access captured once, held on the bus until grant
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && ls_start_i) begin
      lsu_we_o    <= ls_we_i;
      lsu_addr_o  <= ls_addr_i;
      lsu_wdata_o <= ls_wdata_i;
    end
  end

  assign lsu_req_o  = (state_q == ST_REQ);
  // Done in the rvalid cycle, stores included
  assign ls_done_o  = (state_q == ST_WAIT) && lsu_rvalid_i;
  assign ls_rdata_o = lsu_rdata_i;

  // Execute waits for ls_done before it starts again
  a_start_when_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    ls_start_i |-> state_q == ST_IDLE);
  a_word_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    ls_start_i |-> ls_addr_i[1:0] == 2'b00);

endmodule

// ==== source/rv_mini_bus_arbiter.sv ====
////////////////////////////////////////
// Shares the memory bus, LSU first
////////////////////////////////////////

module rv_mini_bus_arbiter (
  input  logic               clk_i,
  input  logic               reset_i,
  // Fetch side
  input  logic               if_req_i,
  input  rv_mini_pkg::word_t if_addr_i,
  output logic               if_gnt_o,
  output logic               if_rvalid_o,
  output rv_mini_pkg::word_t if_rdata_o,
  // LSU side
  input  logic               lsu_req_i,
  input  logic               lsu_we_i,
  input  rv_mini_pkg::word_t lsu_addr_i,
  input  rv_mini_pkg::word_t lsu_wdata_i,
  output logic               lsu_gnt_o,
  output logic               lsu_rvalid_o,
  output rv_mini_pkg::word_t lsu_rdata_o,
  // Memory bus
  output logic               mem_req_o,
  output logic               mem_we_o,
  output rv_mini_pkg::word_t mem_addr_o,
  output rv_mini_pkg::word_t mem_wdata_o,
  input  logic               mem_gnt_i,
  input  logic               mem_rvalid_i,
  input  rv_mini_pkg::word_t mem_rdata_i
);

  // Transaction in flight and who owns it
  logic busy_q;
  logic owner_lsu_q;
  // Request seen without grant, selection frozen
  logic lock_q;
  logic lock_lsu_q;
  logic sel_lsu;

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // Fixed LSU priority, except a stalled request keeps the bus
  assign sel_lsu     = lock_q ? lock_lsu_q : lsu_req_i;
  assign mem_req_o   = !busy_q && (lsu_req_i || if_req_i);
  assign mem_we_o    = sel_lsu && lsu_we_i;
  assign mem_addr_o  = sel_lsu ? lsu_addr_i : if_addr_i;
  assign mem_wdata_o = lsu_wdata_i;

  assign lsu_gnt_o = mem_req_o && sel_lsu && mem_gnt_i;
  assign if_gnt_o  = mem_req_o && !sel_lsu && mem_gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= mem_req_o && !mem_gnt_i;
      if (mem_req_o && mem_gnt_i) begin
        busy_q <= 1'b1;
      end else if (mem_rvalid_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    lock_lsu_q <= sel_lsu;
    if (mem_req_o && mem_gnt_i) begin
      owner_lsu_q <= sel_lsu;
    end
  end

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  assign lsu_rvalid_o = mem_rvalid_i && busy_q && owner_lsu_q;
  assign if_rvalid_o  = mem_rvalid_i && busy_q && !owner_lsu_q;
  assign lsu_rdata_o  = mem_rdata_i;
  assign if_rdata_o   = mem_rdata_i;

  a_one_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    !(if_gnt_o && lsu_gnt_o));
  // Stalled request stays put on the external bus
  a_hold_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_req_o && !mem_gnt_i) |=>
      (mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o)));

endmodule

// ==== source/rv_mini_exec.sv ====
////////////////////////////////////////
// Decode, register file and adder,
// one instruction at a time
////////////////////////////////////////

module rv_mini_exec (
  input  logic                clk_i,
  input  logic                reset_i,
  // From fetch
  input  logic                instr_valid_i,
  input  rv_mini_pkg::instr_t instr_i,
  output logic                instr_take_o,
  // To and from LSU
  output logic                ls_start_o,
  output logic                ls_we_o,
  output rv_mini_pkg::word_t  ls_addr_o,
  output rv_mini_pkg::word_t  ls_wdata_o,
  input  logic                ls_done_i,
  input  rv_mini_pkg::word_t  ls_rdata_i
);

  localparam logic ST_READY = 1'b0;
  localparam logic ST_WAIT  = 1'b1;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_WORD = 3'b010;

  logic                           state_q;
  logic [rv_mini_pkg::REG_AW-1:0] ld_rd_q;
  logic                           ld_pending_q;

  rv_mini_pkg::word_t rf_q [2**rv_mini_pkg::REG_AW];
  rv_mini_pkg::word_t rs1_data;
  rv_mini_pkg::word_t rs2_data;
  rv_mini_pkg::word_t i_imm;
  rv_mini_pkg::word_t s_imm;
  rv_mini_pkg::word_t op_b;
  rv_mini_pkg::word_t sum;

  logic                           is_add;
  logic                           is_addi;
  logic                           is_lw;
  logic                           is_sw;
  logic                           rf_we;
  logic [rv_mini_pkg::REG_AW-1:0] rf_waddr;
  rv_mini_pkg::word_t             rf_wdata;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Anything else falls through as a no-op
  assign is_add  = instr_i.r_fmt.opcode == rv_mini_pkg::OPC_OP &&
                   instr_i.r_fmt.funct3 == F3_ADD && instr_i.r_fmt.funct7 == 7'd0;
  assign is_addi = instr_i.i_fmt.opcode == rv_mini_pkg::OPC_OP_IMM &&
                   instr_i.i_fmt.funct3 == F3_ADD;
  assign is_lw   = instr_i.i_fmt.opcode == rv_mini_pkg::OPC_LOAD &&
                   instr_i.i_fmt.funct3 == F3_WORD;
  assign is_sw   = instr_i.s_fmt.opcode == rv_mini_pkg::OPC_STORE &&
                   instr_i.s_fmt.funct3 == F3_WORD;

  // Sign-extended immediates
  assign i_imm = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
  assign s_imm = {{20{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};

  ////////////////////////////////////////
  // Register read and adder
  ////////////////////////////////////////

  assign rs1_data = rf_q[instr_i.r_fmt.rs1];
  assign rs2_data = rf_q[instr_i.s_fmt.rs2];

  // One adder for ADD, ADDI and the memory address
  always_comb begin
    if (is_add) begin
      op_b = rs2_data;
    end else if (is_sw) begin
      op_b = s_imm;
    end else begin
      op_b = i_imm;
    end
  end

  assign sum = rs1_data + op_b;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  assign instr_take_o = (state_q == ST_READY) && instr_valid_i;
  assign ls_start_o   = instr_take_o && (is_lw || is_sw);
  assign ls_we_o      = is_sw;
  assign ls_addr_o    = sum;
  assign ls_wdata_o   = rs2_data;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_READY;
    end else if (ls_start_o) begin
      state_q <= ST_WAIT;
    end else if (state_q == ST_WAIT && ls_done_i) begin
      state_q <= ST_READY;
    end
  end

  // Load destination kept once the instruction leaves the buffer
  always_ff @(posedge clk_i) begin
    if (ls_start_o) begin
      ld_rd_q      <= instr_i.i_fmt.rd;
      ld_pending_q <= is_lw;
    end
  end

  // Single write port, ALU result or load data
  always_comb begin
    rf_waddr = instr_i.r_fmt.rd;
    rf_wdata = sum;
    rf_we    = instr_take_o && (is_add || is_addi);
    if (state_q == ST_WAIT) begin
      rf_waddr = ld_rd_q;
      rf_wdata = ls_rdata_i;
      rf_we    = ls_done_i && ld_pending_q;
    end
  end

  // x0 cleared on reset and never written afterwards
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rf_q[0] <= '0;
    end else if (rf_we && rf_waddr != '0) begin
      rf_q[rf_waddr] <= rf_wdata;
    end
  end

  a_x0_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    rf_q[0] == '0);

endmodule

// ==== source/rv_mini_core.sv ====
////////////////////////////////////////
// Core top, fetch and LSU on one bus
////////////////////////////////////////

module rv_mini_core #(
  parameter rv_mini_pkg::word_t BOOT_ADDR = '0
) (
  input  logic               clk_i,
  input  logic               reset_i,
  // Shared memory bus
  output logic               mem_req_o,
  output logic               mem_we_o,
  output rv_mini_pkg::word_t mem_addr_o,
  output rv_mini_pkg::word_t mem_wdata_o,
  input  logic               mem_gnt_i,
  input  logic               mem_rvalid_i,
  input  rv_mini_pkg::word_t mem_rdata_i
);

  // Fetch to arbiter
  logic                if_req;
  rv_mini_pkg::word_t  if_addr;
  logic                if_gnt;
  logic                if_rvalid;
  rv_mini_pkg::word_t  if_rdata;
  // LSU to arbiter
  logic                lsu_req;
  logic                lsu_we;
  rv_mini_pkg::word_t  lsu_addr;
  rv_mini_pkg::word_t  lsu_wdata;
  logic                lsu_gnt;
  logic                lsu_rvalid;
  rv_mini_pkg::word_t  lsu_rdata;
  // Fetch to execute
  logic                instr_valid;
  rv_mini_pkg::instr_t instr;
  logic                instr_take;
  // Execute to LSU
  logic                ls_start;
  logic                ls_we;
  rv_mini_pkg::word_t  ls_addr;
  rv_mini_pkg::word_t  ls_wdata;
  logic                ls_done;
  rv_mini_pkg::word_t  ls_rdata;

  rv_mini_fetch #(
    .BOOT_ADDR (BOOT_ADDR)
  ) fetch0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .if_req_o      (if_req),
    .if_addr_o     (if_addr),
    .if_gnt_i      (if_gnt),
    .if_rvalid_i   (if_rvalid),
    .if_rdata_i    (if_rdata),
    .instr_valid_o (instr_valid),
    .instr_o       (instr),
    .instr_take_i  (instr_take)
  );

  rv_mini_exec exec0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .instr_take_o  (instr_take),
    .ls_start_o    (ls_start),
    .ls_we_o       (ls_we),
    .ls_addr_o     (ls_addr),
    .ls_wdata_o    (ls_wdata),
    .ls_done_i     (ls_done),
    .ls_rdata_i    (ls_rdata)
  );

  rv_mini_lsu lsu0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ls_start_i   (ls_start),
    .ls_we_i      (ls_we),
    .ls_addr_i    (ls_addr),
    .ls_wdata_i   (ls_wdata),
    .ls_done_o    (ls_done),
    .ls_rdata_o   (ls_rdata),
    .lsu_req_o    (lsu_req),
    .lsu_we_o     (lsu_we),
    .lsu_addr_o   (lsu_addr),
    .lsu_wdata_o  (lsu_wdata),
    .lsu_gnt_i    (lsu_gnt),
    .lsu_rvalid_i (lsu_rvalid),
    .lsu_rdata_i  (lsu_rdata)
  );

  rv_mini_bus_arbiter arb0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .if_req_i     (if_req),
    .if_addr_i    (if_addr),
    .if_gnt_o     (if_gnt),
    .if_rvalid_o  (if_rvalid),
    .if_rdata_o   (if_rdata),
    .lsu_req_i    (lsu_req),
    .lsu_we_i     (lsu_we),
    .lsu_addr_i   (lsu_addr),
    .lsu_wdata_i  (lsu_wdata),
    .lsu_gnt_o    (lsu_gnt),
    .lsu_rvalid_o (lsu_rvalid),
    .lsu_rdata_o  (lsu_rdata),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

endmodule

// ==== test/rv_mini_checker.sv ====
////////////////////////////////////////
// Bus checker with ISA reference model
////////////////////////////////////////

module rv_mini_checker #(
  parameter rv_mini_pkg::word_t BOOT_ADDR = '0,
  parameter int                 PROG_LEN  = 60
) (
  input  logic               clk_i,
  input  logic               reset_i,
  // Observed memory bus
  input  logic               req_i,
  input  logic               we_i,
  input  rv_mini_pkg::word_t addr_i,
  input  rv_mini_pkg::word_t wdata_i,
  input  logic               gnt_i,
  input  logic               rvalid_i,
  output logic               done_o,
  output int                 value_errs_o,
  output int                 proto_errs_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Instruction fetches stay inside the 512-word program area
  localparam rv_mini_pkg::word_t PROG_END = BOOT_ADDR + 32'h800;

  rv_mini_pkg::word_t model_mem [1024];
  rv_mini_pkg::word_t model_rf [32];
  int                 model_pc;
  rv_mini_pkg::word_t next_fetch;
  logic               outstanding;
  // Previous cycle still in reset
  logic               reset_prev;
  // Previous cycle stalled, and what it carried
  logic               stall_prev;
  rv_mini_pkg::word_t prev_addr;
  logic               prev_we;
  rv_mini_pkg::word_t prev_wdata;
  int                 stores_total;
  int                 stores_seen;

  assign done_o = (stores_seen == stores_total);

  initial begin
    value_errs_o = 0;
    proto_errs_o = 0;
  end

  task automatic report_value(input string name, input rv_mini_pkg::word_t exp,
                              input rv_mini_pkg::word_t got);
    value_errs_o++;
    $display("FAILED %0t %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic report_protocol(input string what);
    proto_errs_o++;
    $display("ERROR %0t %s", $time, what);
  endtask

  task automatic write_reg(input logic [4:0] rd, input rv_mini_pkg::word_t value);
    // x0 stays zero
    if (rd != 5'd0) begin
      model_rf[rd] = value;
    end
  endtask

  // Retire instructions in order up to and including the next LW or SW
  task automatic step_to_mem_op(output logic found, output logic we,
                                output rv_mini_pkg::word_t addr,
                                output rv_mini_pkg::word_t wdata);
    rv_mini_pkg::instr_t ins;
    rv_mini_pkg::word_t  src1;
    rv_mini_pkg::word_t  imm_i;
    rv_mini_pkg::word_t  imm_s;
    found = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    while (!found && model_pc < PROG_LEN) begin
      ins   = model_mem[model_pc];
      model_pc++;
      src1  = model_rf[ins.r_fmt.rs1];
      imm_i = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
      imm_s = {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
      case (ins.r_fmt.opcode)
        rv_mini_pkg::OPC_OP: begin
          if (ins.r_fmt.funct3 == 3'b000 && ins.r_fmt.funct7 == 7'd0) begin
            write_reg(ins.r_fmt.rd, src1 + model_rf[ins.r_fmt.rs2]);
          end
        end
        rv_mini_pkg::OPC_OP_IMM: begin
          if (ins.i_fmt.funct3 == 3'b000) begin
            write_reg(ins.i_fmt.rd, src1 + imm_i);
          end
        end
        rv_mini_pkg::OPC_LOAD: begin
          if (ins.i_fmt.funct3 == 3'b010) begin
            found = 1'b1;
            addr  = src1 + imm_i;
            write_reg(ins.i_fmt.rd, model_mem[addr[11:2]]);
          end
        end
        rv_mini_pkg::OPC_STORE: begin
          if (ins.s_fmt.funct3 == 3'b010) begin
            found = 1'b1;
            we    = 1'b1;
            addr  = src1 + imm_s;
            wdata = model_rf[ins.s_fmt.rs2];
            model_mem[addr[11:2]] = wdata;
          end
        end
        // Unknown opcodes retire as no-ops
        default: ;
      endcase
    end
  endtask

  always @(posedge clk_i) begin : watch_bus
    int                  r;
    logic                found;
    logic                exp_we;
    rv_mini_pkg::word_t  exp_addr;
    rv_mini_pkg::word_t  exp_wdata;
    rv_mini_pkg::instr_t ins;
    if (reset_i) begin
      // Bus stays quiet through reset
      if (req_i === 1'b1) report_value("mem_req_o", '0, 32'd1);
      reset_prev   = 1'b1;
      model_pc     = 0;
      next_fetch   = BOOT_ADDR;
      outstanding  = 1'b0;
      stall_prev   = 1'b0;
      stores_seen  = 0;
      stores_total = 0;
      for (r = 0; r < 32; r++) begin
        model_rf[r] = '0;
      end
      for (r = 0; r < PROG_LEN; r++) begin
        ins = model_mem[r];
        if (ins.s_fmt.opcode == rv_mini_pkg::OPC_STORE && ins.s_fmt.funct3 == 3'b010) begin
          stores_total++;
        end
      end
    end else begin
      // And for one more cycle after it
      if (reset_prev && req_i === 1'b1) report_value("mem_req_o", '0, 32'd1);
      reset_prev = 1'b0;
      if (req_i && outstanding) begin
        report_protocol("new request before the previous rvalid");
      end
      ///////// Held request under back-pressure
      if (stall_prev) begin
        if (!req_i) begin
          report_protocol("request dropped before gnt");
        end else begin
          if (addr_i !== prev_addr) report_value("mem_addr_o", prev_addr, addr_i);
          if (we_i !== prev_we) begin
            report_value("mem_we_o", rv_mini_pkg::word_t'(prev_we), rv_mini_pkg::word_t'(we_i));
          end
          if (prev_we && wdata_i !== prev_wdata) begin
            report_value("mem_wdata_o", prev_wdata, wdata_i);
          end
        end
      end
      if (rvalid_i) begin
        outstanding = 1'b0;
      end
      if (req_i && gnt_i) begin
        outstanding = 1'b1;
        if (!we_i && addr_i < PROG_END) begin
          // Sequential fetch, resync so one slip reports once
          if (addr_i !== next_fetch) report_value("mem_addr_o", next_fetch, addr_i);
          next_fetch = addr_i + 32'd4;
        end else begin
          step_to_mem_op(found, exp_we, exp_addr, exp_wdata);
          if (!found) begin
            report_protocol("data access with no load or store left in the program");
          end else begin
            if (we_i !== exp_we) begin
              report_value("mem_we_o", rv_mini_pkg::word_t'(exp_we), rv_mini_pkg::word_t'(we_i));
            end
            if (addr_i !== exp_addr) report_value("mem_addr_o", exp_addr, addr_i);
            if (exp_we && we_i && wdata_i !== exp_wdata) begin
              report_value("mem_wdata_o", exp_wdata, wdata_i);
            end
          end
          if (we_i) stores_seen++;
        end
      end
      stall_prev = req_i && !gnt_i;
      prev_addr  = addr_i;
      prev_we    = we_i;
      prev_wdata = wdata_i;
    end
  end

endmodule

// ==== test/rv_mini_tb.sv ====
////////////////////////////////////////
// Testbench top, random program and
// memory model with random bus delays
////////////////////////////////////////

module rv_mini_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam rv_mini_pkg::word_t BOOT_ADDR = '0;
  localparam int PROG_LEN  = 60;
  localparam int MEM_WORDS = 1024;
  // Slowest instruction plus slack for reset and drain
  localparam int TIMEOUT_CYCLES = PROG_LEN * 12 + 100;

  logic               clk_i        = 1'b0;
  logic               reset_i      = 1'b1;
  logic               mem_gnt_i    = 1'b0;
  logic               mem_rvalid_i = 1'b0;
  rv_mini_pkg::word_t mem_rdata_i  = '0;
  logic               mem_req_o;
  logic               mem_we_o;
  rv_mini_pkg::word_t mem_addr_o;
  rv_mini_pkg::word_t mem_wdata_o;

  int                 seed = 95177;
  rv_mini_pkg::word_t mem [MEM_WORDS];

  // Memory model state
  logic               pending;
  int                 gnt_cnt;
  int                 rsp_cnt;
  rv_mini_pkg::word_t rsp_data;

  logic chk_done;
  int   value_errs;
  int   proto_errs;
  logic timed_out;

  always #10 clk_i = ~clk_i;

  rv_mini_core #(
    .BOOT_ADDR (BOOT_ADDR)
  ) dut0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  rv_mini_checker #(
    .BOOT_ADDR (BOOT_ADDR),
    .PROG_LEN  (PROG_LEN)
  ) chk0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (mem_req_o),
    .we_i         (mem_we_o),
    .addr_i       (mem_addr_o),
    .wdata_i      (mem_wdata_o),
    .gnt_i        (mem_gnt_i),
    .rvalid_i     (mem_rvalid_i),
    .done_o       (chk_done),
    .value_errs_o (value_errs),
    .proto_errs_o (proto_errs)
  );

  ////////////////////////////////////////
  // Program and data image
  ////////////////////////////////////////

  initial begin : build_image
    int          i;
    int          kind;
    logic [31:0] rnd;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    for (i = 0; i < MEM_WORDS; i++) begin
      if (i < 512) begin
        mem[i] = rv_mini_pkg::NOP_INSTR;
      end else if (i < 576) begin
        mem[i] = $random(seed);
      end else begin
        // Unused words, tagged with their own index
        mem[i] = {i[15:0], ~i[15:0]};
      end
    end
    for (i = 0; i < PROG_LEN; i++) begin
      rnd  = $random(seed);
      kind = {$random(seed)} % 10;
      rd   = {2'b00, rnd[2:0]};
      rs1  = {2'b00, rnd[5:3]};
      rs2  = {2'b00, rnd[8:6]};
      // x0 base plus -2048 lands in the data area at word 512
      imm  = 12'h800 + {4'd0, rnd[14:9], 2'b00};
      if (i < 7) begin
        // Seed x1..x7 so no source is ever undefined
        mem[i] = {rnd[31:20], 5'd0, 3'b000, 5'(i + 1), rv_mini_pkg::OPC_OP_IMM};
      end else begin
        case (kind)
          0, 1: mem[i] = {7'd0, rs2, rs1, 3'b000, rd, rv_mini_pkg::OPC_OP};
          2, 3: mem[i] = {rnd[31:20], rs1, 3'b000, rd, rv_mini_pkg::OPC_OP_IMM};
          4, 5: mem[i] = {imm, 5'd0, 3'b010, rd, rv_mini_pkg::OPC_LOAD};
          6, 7, 8: begin
            mem[i] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rv_mini_pkg::OPC_STORE};
          end
          // LUI or custom-2, both outside the subset
          default: mem[i] = {rnd[31:7], rnd[15] ? 7'b0110111 : 7'b1011011};
        endcase
      end
    end
    for (i = 0; i < MEM_WORDS; i++) begin
      chk0.model_mem[i] = mem[i];
    end
  end

  ////////////////////////////////////////
  // Memory model, one access at a time
  ////////////////////////////////////////

  always @(posedge clk_i) begin : mem_model
    logic [9:0] idx;
    int         delay;
    idx = mem_addr_o[11:2];
    if (reset_i) begin
      mem_gnt_i    <= 1'b0;
      mem_rvalid_i <= 1'b0;
      pending      <= 1'b0;
      gnt_cnt      <= {$random(seed)} % 4;
    end else begin
      mem_rvalid_i <= 1'b0;
      if (mem_req_o && mem_gnt_i) begin
        // Handshake, pick response latency of 1 to 3 cycles
        mem_gnt_i <= 1'b0;
        gnt_cnt   <= {$random(seed)} % 4;
        delay     = {$random(seed)} % 3;
        if (delay == 0) begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= mem[idx];
        end else begin
          pending  <= 1'b1;
          rsp_cnt  <= delay - 1;
          rsp_data <= mem[idx];
        end
        if (mem_we_o) begin
          mem[idx] = mem_wdata_o;
        end
      end else if (pending) begin
        if (rsp_cnt == 0) begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= rsp_data;
          pending      <= 1'b0;
        end else begin
          rsp_cnt <= rsp_cnt - 1;
        end
      end else if (mem_req_o) begin
        // Grant once the random back-pressure has run out
        if (gnt_cnt == 0) begin
          mem_gnt_i <= 1'b1;
        end else begin
          gnt_cnt <= gnt_cnt - 1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Reset, run length and verdict
  ////////////////////////////////////////

  initial begin : run_control
    int cycles;
    cycles = 0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    while (!chk_done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    timed_out = !chk_done;
    // Let the last response drain
    repeat (4) @(negedge clk_i);
    if (timed_out) begin
      $display("Run timed out after %0d cycles before all stores were seen", cycles);
    end
    $display("Errors: value=%0d protocol=%0d timeout=%0d", value_errs, proto_errs, timed_out);
    if (value_errs == 0 && proto_errs == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== rv_mini.f ====
source/rv_mini_pkg.sv
source/rv_mini_fetch.sv
source/rv_mini_lsu.sv
source/rv_mini_bus_arbiter.sv
source/rv_mini_exec.sv
source/rv_mini_core.sv
test/rv_mini_checker.sv
test/rv_mini_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_mini testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --top-module rv_mini_tb -f rv_mini.f -o rv_mini_sim

if ! ./obj_dir/rv_mini_sim > sim.log 2>&1; then
  cat sim.log
  exit 1
fi
cat sim.log

if grep -qx "Simulation passed" sim.log; then
  exit 0
else
  exit 1
fi
